//--- design/notchPkg.sv
// shared widths, filter coefficients, status codes and bus structs for the notch accelerator RTL
`default_nettype none

package notchPkg;

	localparam int addrWidth = 24;		// memory byte address
	localparam int sampleWidth = 32;	// one signed sample
	localparam int accWidth = 64;		// accumulator and y history
	localparam int coeffWidth = 16;
	localparam int coeffFrac = 14;		// fraction bits dropped after the sum
	localparam int fifoDepth = 16;
	localparam int fifoPtrWidth = 4;	// log2 of fifoDepth
	localparam int fifoCntWidth = 5;	// occupancy, 0 to fifoDepth
	localparam int maxOutstanding = 8;	// reads in flight

	typedef logic signed [sampleWidth-1:0] sample_t;
	typedef logic signed [accWidth-1:0] acc_t;
	typedef logic signed [coeffWidth-1:0] coeff_t;
	typedef logic [addrWidth-1:0] memAddr_t;

	typedef enum logic [1:0] {
		stageIdle = 2'd0,
		stageRunning = 2'd1,
		stageFinished = 2'd2	// waits for irq service
	} stage_t;

	// notch section, scaled by 2^14
	localparam coeff_t coeffB0 = 16'sd8275;
	localparam coeff_t coeffB1 = -16'sd16383;
	localparam coeff_t coeffB2 = 16'sd8275;
	localparam coeff_t coeffA1 = -16'sd31035;
	localparam coeff_t coeffA2 = 16'sd14969;

	localparam logic [3:0] statRead = 4'd0;		// bytes requested
	localparam logic [3:0] statReceived = 4'd1;
	localparam logic [3:0] statComputed = 4'd2;
	localparam logic [3:0] statWritten = 4'd3;
	localparam logic [3:0] statStage = 4'd4;

	localparam logic [31:0] replyAccepted = 32'd99;	// job taken
	localparam logic [31:0] replyIdle = 32'hffff_ffff;

	typedef struct packed {
		logic start;		// one cycle, job begins
		logic active;		// high while running
		memAddr_t base;
		logic [31:0] count;	// samples in the job
	} jobDesc_t;

	typedef struct packed {
		logic read;
		logic write;
		memAddr_t address;
		sample_t writeData;
	} memCmd_t;

endpackage

`default_nettype wire

//--- design/sampleFifo.sv
// first-word-fall-through sample FIFO, instantiated for the read samples and for the filter results
`timescale 1ns/1ps
`default_nettype none

module sampleFifo (
	input wire clk,
	input wire rstN,
	input wire clear,					// empties in one cycle
	input wire push,
	input wire notchPkg::sample_t pushData,
	input wire pop,
	output notchPkg::sample_t popData,
	output logic empty,
	output logic full,
	output logic [notchPkg::fifoCntWidth-1:0] used
);

	notchPkg::sample_t store [notchPkg::fifoDepth];	// no reset, payload only
	logic [notchPkg::fifoPtrWidth-1:0] wrPtr;
	logic [notchPkg::fifoPtrWidth-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;		// drop on overflow
	assign doPop = pop && !empty;
	assign empty = (used == '0);
	assign full = (int'(used) == notchPkg::fifoDepth);
	assign popData = store[rdPtr];		// head always visible

	always_ff @(posedge clk) begin
		if (doPush) begin
			store[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			used <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;	// both or none
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/sampleReader.sv
// read engine that keeps pipelined memory reads in flight for a job and counts returned words
`timescale 1ns/1ps
`default_nettype none

module sampleReader (
	input wire clk,
	input wire rstN,
	input wire notchPkg::jobDesc_t job,
	output notchPkg::memCmd_t readCmd,
	input wire readAccepted,			// our read went out this cycle
	input wire memReadDataValid,
	input wire [notchPkg::fifoCntWidth-1:0] fifoUsed,
	output logic [31:0] readBytes,
	output logic [31:0] receivedCount
);

	notchPkg::memAddr_t readAddr;		// next word to request
	notchPkg::memAddr_t endAddr;
	logic [notchPkg::fifoCntWidth-1:0] outstanding;
	logic addrLeft;
	logic room;

	assign endAddr = job.base + notchPkg::memAddr_t'({job.count, 2'b00});	// base + 4*count
	assign addrLeft = (readAddr != endAddr);

	// in flight plus queued must fit the sample FIFO
	assign room = (int'(outstanding) + int'(fifoUsed) < notchPkg::fifoDepth)
		&& (int'(outstanding) < notchPkg::maxOutstanding);

	// strobe only changes on acceptance, so it holds while stalled
	always_comb begin
		readCmd = '0;
		readCmd.read = job.active && !job.start && addrLeft && room;
		readCmd.address = readAddr;
	end

	assign readBytes = 32'(readAddr - job.base);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			readAddr <= '0;
			outstanding <= '0;
			receivedCount <= '0;
		end else if (job.start) begin
			readAddr <= job.base;		// fresh job
			outstanding <= '0;
			receivedCount <= '0;
		end else begin
			if (readAccepted) begin
				readAddr <= readAddr + notchPkg::memAddr_t'(4);
			end
			case ({readAccepted, memReadDataValid})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;	// issue and return cancel
			endcase
			if (memReadDataValid) begin
				receivedCount <= receivedCount + 32'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/biquadCore.sv
// direct-form-I biquad with fixed notch coefficients, pops one sample and pushes one result
`timescale 1ns/1ps
`default_nettype none

module biquadCore (
	input wire clk,
	input wire rstN,
	input wire clear,					// new job, drop history
	input wire inEmpty,
	input wire notchPkg::sample_t inData,
	output logic inPop,
	input wire outFull,
	output logic outPush,
	output notchPkg::sample_t outData,
	output logic [31:0] computedCount
);

	notchPkg::sample_t x1;				// x(n-1)
	notchPkg::sample_t x2;				// x(n-2)
	notchPkg::acc_t y1;					// y(n-1), full width
	notchPkg::acc_t y2;					// y(n-2)
	notchPkg::acc_t pB0;
	notchPkg::acc_t pB1;
	notchPkg::acc_t pB2;
	notchPkg::acc_t pA1;
	notchPkg::acc_t pA2;
	notchPkg::acc_t sumReg;
	logic prodValid;
	logic sumValid;
	logic resValid;						// result waiting for FIFO room
	logic busy;

	assign busy = prodValid || sumValid || resValid;	// one sample at a time, y feeds back
	assign inPop = !clear && !busy && !inEmpty;
	assign outPush = resValid && !outFull;
	assign outData = notchPkg::sample_t'(y1[notchPkg::sampleWidth-1:0]);	// low word of y(n)

	// stage tracking and result count
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			prodValid <= 1'b0;
			sumValid <= 1'b0;
			resValid <= 1'b0;
			computedCount <= '0;
		end else begin
			prodValid <= inPop;
			sumValid <= prodValid;
			if (sumValid) begin
				resValid <= 1'b1;
			end else if (outPush) begin
				resValid <= 1'b0;
			end
			if (outPush) begin
				computedCount <= computedCount + 32'd1;
			end
		end
	end

	// products then sum, wrap at 64 bits
	always_ff @(posedge clk) begin
		if (inPop) begin
			pB0 <= notchPkg::acc_t'(inData) * notchPkg::acc_t'(notchPkg::coeffB0);
			pB1 <= notchPkg::acc_t'(x1) * notchPkg::acc_t'(notchPkg::coeffB1);
			pB2 <= notchPkg::acc_t'(x2) * notchPkg::acc_t'(notchPkg::coeffB2);
			pA1 <= y1 * notchPkg::acc_t'(notchPkg::coeffA1);
			pA2 <= y2 * notchPkg::acc_t'(notchPkg::coeffA2);
		end
		if (prodValid) begin
			sumReg <= pB0 + pB1 + pB2 - pA1 - pA2;	// feedback terms subtracted
		end
	end

	// histories, cleared per job
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end else begin
			if (inPop) begin
				x1 <= inData;
				x2 <= x1;
			end
			if (sumValid) begin
				y1 <= sumReg >>> notchPkg::coeffFrac;	// drop coefficient scale
				y2 <= y1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/resultWriter.sv
// write engine that drains filter results to memory and merges them with the reader's commands
`timescale 1ns/1ps
`default_nettype none

module resultWriter (
	input wire clk,
	input wire rstN,
	input wire notchPkg::jobDesc_t job,
	input wire notchPkg::memCmd_t readCmd,
	output logic readAccepted,
	input wire outEmpty,
	input wire notchPkg::sample_t outData,
	output logic outPop,
	output notchPkg::memCmd_t mem,
	input wire memWaitRequest,
	output logic [31:0] writtenCount
);

	logic writing;						// write strobe held until accepted
	notchPkg::sample_t wrData;
	logic startWrite;
	logic writeAccepted;

	// reads have priority, a write only starts when no read is up
	assign startWrite = job.active && !job.start && !writing && !outEmpty && !readCmd.read;
	assign outPop = startWrite;			// head captured on the same edge
	assign writeAccepted = writing && !memWaitRequest;
	assign readAccepted = readCmd.read && !writing && !memWaitRequest;

	always_comb begin
		mem = '0;
		if (writing) begin
			mem.write = 1'b1;
			mem.address = job.base + notchPkg::memAddr_t'({writtenCount, 2'b00});	// in place
			mem.writeData = wrData;
		end else begin
			mem.read = readCmd.read;
			mem.address = readCmd.address;
		end
	end

	always_ff @(posedge clk) begin
		if (startWrite) begin
			wrData <= outData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || job.start) begin
			writing <= 1'b0;
			writtenCount <= '0;
		end else if (startWrite) begin
			writing <= 1'b1;
		end else if (writeAccepted) begin
			writing <= 1'b0;
			writtenCount <= writtenCount + 32'd1;	// address moves with it
		end
	end

endmodule

`default_nettype wire

//--- design/notchControl.sv
// job controller that answers custom instructions, tracks the job stage and serves status reads
`timescale 1ns/1ps
`default_nettype none

module notchControl (
	input wire clk,
	input wire rstN,
	input wire start,
	input wire [31:0] dataa,			// base byte address
	input wire [31:0] datab,			// sample count
	output logic [31:0] result,
	output logic done,
	input wire slaveRead,
	input wire [3:0] slaveAddress,
	output logic [31:0] slaveReadData,
	output logic irq,
	output notchPkg::jobDesc_t job,
	input wire [31:0] readBytes,
	input wire [31:0] receivedCount,
	input wire [31:0] computedCount,
	input wire [31:0] writtenCount
);

	notchPkg::stage_t stage;
	logic jobDone;

	// counters are stale while start is up
	assign jobDone = (stage == notchPkg::stageRunning) && !job.start
		&& (writtenCount == job.count);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stage <= notchPkg::stageIdle;
			job <= '0;
			done <= 1'b0;
			irq <= 1'b0;
		end else begin
			done <= start;				// reply next cycle
			job.start <= 1'b0;
			if (start && stage == notchPkg::stageIdle && dataa != '0) begin
				job.start <= 1'b1;
				job.active <= 1'b1;
				job.base <= dataa[notchPkg::addrWidth-1:0];
				job.count <= datab;
				stage <= notchPkg::stageRunning;
			end
			if (jobDone) begin
				job.active <= 1'b0;
				irq <= 1'b1;
				stage <= notchPkg::stageFinished;
			end
			if (stage == notchPkg::stageFinished && slaveRead) begin	// any read services irq
				irq <= 1'b0;
				stage <= notchPkg::stageIdle;
			end
		end
	end

	// custom-instruction reply
	always_ff @(posedge clk) begin
		if (start) begin
			case (stage)
				notchPkg::stageIdle: result <= (dataa != '0) ? notchPkg::replyAccepted
					: notchPkg::replyIdle;
				notchPkg::stageRunning: result <= writtenCount;	// progress
				notchPkg::stageFinished: result <= 32'(stage);
				default: result <= notchPkg::replyIdle;
			endcase
		end
	end

	// status slave, one cycle read latency
	always_ff @(posedge clk) begin
		if (slaveRead) begin
			case (slaveAddress)
				notchPkg::statRead: slaveReadData <= readBytes;
				notchPkg::statReceived: slaveReadData <= receivedCount;
				notchPkg::statComputed: slaveReadData <= computedCount;
				notchPkg::statWritten: slaveReadData <= writtenCount;
				notchPkg::statStage: slaveReadData <= 32'(stage);
				default: slaveReadData <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/notchTop.sv
// notch accelerator top level, joins controller, read and write engines, FIFOs and the biquad
`timescale 1ns/1ps
`default_nettype none

module notchTop (
	input wire clk,
	input wire rstN,
	input wire start,
	input wire [31:0] dataa,
	input wire [31:0] datab,
	output logic [31:0] result,
	output logic done,
	output notchPkg::memCmd_t mem,
	input wire memWaitRequest,
	input wire notchPkg::sample_t memReadData,
	input wire memReadDataValid,
	input wire slaveRead,
	input wire [3:0] slaveAddress,
	output logic [31:0] slaveReadData,
	output logic irq
);

	notchPkg::jobDesc_t job;
	notchPkg::memCmd_t readCmd;			// reader to writer mux
	logic readAccepted;
	logic [notchPkg::fifoCntWidth-1:0] inUsed;
	logic [31:0] readBytes;
	logic [31:0] receivedCount;
	logic [31:0] computedCount;
	logic [31:0] writtenCount;
	notchPkg::sample_t inHead;
	logic inEmpty;
	logic inPop;
	notchPkg::sample_t filtData;
	logic filtPush;
	logic outFull;
	notchPkg::sample_t outHead;
	logic outEmpty;
	logic outPop;

	notchControl control (.clk(clk), .rstN(rstN), .start(start), .dataa(dataa), .datab(datab),
		.result(result), .done(done), .slaveRead(slaveRead), .slaveAddress(slaveAddress),
		.slaveReadData(slaveReadData), .irq(irq), .job(job), .readBytes(readBytes),
		.receivedCount(receivedCount), .computedCount(computedCount),
		.writtenCount(writtenCount));

	sampleReader reader (.clk(clk), .rstN(rstN), .job(job), .readCmd(readCmd),
		.readAccepted(readAccepted), .memReadDataValid(memReadDataValid), .fifoUsed(inUsed),
		.readBytes(readBytes), .receivedCount(receivedCount));

	sampleFifo inFifo (.clk(clk), .rstN(rstN), .clear(job.start), .push(memReadDataValid),
		.pushData(memReadData), .pop(inPop), .popData(inHead), .empty(inEmpty), .full(),
		.used(inUsed));		// every returned word goes straight in

	biquadCore filter (.clk(clk), .rstN(rstN), .clear(job.start), .inEmpty(inEmpty),
		.inData(inHead), .inPop(inPop), .outFull(outFull), .outPush(filtPush),
		.outData(filtData), .computedCount(computedCount));

	sampleFifo outFifo (.clk(clk), .rstN(rstN), .clear(job.start), .push(filtPush),
		.pushData(filtData), .pop(outPop), .popData(outHead), .empty(outEmpty),
		.full(outFull), .used());

	resultWriter writer (.clk(clk), .rstN(rstN), .job(job), .readCmd(readCmd),
		.readAccepted(readAccepted), .outEmpty(outEmpty), .outData(outHead), .outPop(outPop),
		.mem(mem), .memWaitRequest(memWaitRequest), .writtenCount(writtenCount));

endmodule

`default_nettype wire

//--- verif/notchTop_sva.sv
// bus and control assertions for the notch accelerator, bound into every notchTop instance
`timescale 1ns/1ps
`default_nettype none

module notchTop_sva (
	input wire clk,
	input wire rstN,
	input wire start,
	input wire done,
	input wire notchPkg::memCmd_t mem,
	input wire memWaitRequest,
	input wire irq,
	input wire notchPkg::stage_t stage
);

	assert property (@(posedge clk) disable iff (!rstN) !(mem.read && mem.write))
		else $error("read and write strobes raised together");

	assert property (@(posedge clk) disable iff (!rstN) done |-> $past(start))
		else $error("done without a start in the cycle before");

	// stalled write keeps strobe, address and data
	assert property (@(posedge clk) disable iff (!rstN) mem.write && memWaitRequest
		|=> mem.write && $stable(mem.address) && $stable(mem.writeData))
		else $error("write changed before it was accepted");

	assert property (@(posedge clk) disable iff (!rstN) stage == notchPkg::stageIdle |-> !irq)
		else $error("irq high in the idle stage");

endmodule

bind notchTop notchTop_sva sva (.clk(clk), .rstN(rstN), .start(start), .done(done), .mem(mem),
	.memWaitRequest(memWaitRequest), .irq(irq), .stage(control.stage));

`default_nettype wire

//--- verif/notchTb.sv
// testbench for the notch accelerator, runs two filter jobs against a memory model and a reference
`timescale 1ns/1ps
`default_nettype none

module notchTb;

	localparam int job1Count = 40;
	localparam int job2Count = 25;
	localparam int timeoutCycles = 20 * (job1Count + job2Count) + 200 * 2;	// per sample plus per job
	localparam logic [31:0] rngSeed = 32'h4626c5e8;

	logic clk;
	logic rstN;
	logic start;
	logic [31:0] dataa;
	logic [31:0] datab;
	logic [31:0] result;
	logic done;
	notchPkg::memCmd_t mem;
	logic memWaitRequest;
	notchPkg::sample_t memReadData;
	logic memReadDataValid;
	logic slaveRead;
	logic [3:0] slaveAddress;
	logic [31:0] slaveReadData;
	logic irq;

	logic [31:0] memory [512];			// word array indexed by byte address bits 10:2
	logic [31:0] readQ [$];				// data of accepted reads
	int dueQ [$];						// cycle each read returns
	logic [31:0] waitState;
	logic [31:0] sampleState;
	logic [31:0] jobBase;				// range writes must hit
	int jobCount;
	int cycles;
	int mismatchCount;
	int failCount;

	notchTop DUT (.clk(clk), .rstN(rstN), .start(start), .dataa(dataa), .datab(datab),
		.result(result), .done(done), .mem(mem), .memWaitRequest(memWaitRequest),
		.memReadData(memReadData), .memReadDataValid(memReadDataValid), .slaveRead(slaveRead),
		.slaveAddress(slaveAddress), .slaveReadData(slaveReadData), .irq(irq));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;			// 100 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one notch biquad output in 64-bit signed math with the 2^14 scale removed
	function automatic longint biquadStep(input longint x0, input longint x1, input longint x2,
		input longint y1, input longint y2);
		longint sum;
		sum = x0 * longint'(notchPkg::coeffB0) + x1 * longint'(notchPkg::coeffB1)
			+ x2 * longint'(notchPkg::coeffB2) - y1 * longint'(notchPkg::coeffA1)
			- y2 * longint'(notchPkg::coeffA2);
		return sum >>> 14;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finishRun();
		$display("checks finished: %0d mismatches, %0d other errors", mismatchCount, failCount);
		if (mismatchCount + failCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	task automatic storeWrite(input notchPkg::memAddr_t addr, input logic [31:0] data);
		if (32'(addr) < jobBase || 32'(addr) >= jobBase + 32'(4 * jobCount) || addr[1:0] != 0) begin
			failCount++;
			$display("write outside the job range at %0t ns, address %h", $time, addr);
		end else begin
			memory[addr[10:2]] = data;
		end
	endtask

	// custom instruction that returns the reply seen with done
	task automatic issueInstr(input logic [31:0] a, input logic [31:0] b, output logic [31:0] reply);
		@(posedge clk);
		#1;
		start = 1'b1;
		dataa = a;
		datab = b;
		@(negedge clk);
		checkEq("done", 32'(done), 32'd0);	// not in the start cycle
		@(posedge clk);
		#1;
		start = 1'b0;
		dataa = '0;
		datab = '0;
		@(negedge clk);
		checkEq("done", 32'(done), 32'd1);
		reply = result;
		@(negedge clk);
		checkEq("done", 32'(done), 32'd0);	// one cycle only
	endtask

	task automatic readStatus(input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		slaveRead = 1'b1;
		slaveAddress = addr;
		@(posedge clk);
		#1;
		slaveRead = 1'b0;
		@(negedge clk);
		data = slaveReadData;			// registered a cycle after the read
	endtask

	task automatic runJob(input logic [31:0] base, input int count);
		logic [31:0] reply;
		logic [31:0] prevReply;
		logic [31:0] word;
		longint x1;
		longint x2;
		longint y1;
		longint y2;
		longint y;
		int expected [$];
		int i;
		x1 = 0;
		x2 = 0;
		y1 = 0;
		y2 = 0;
		for (i = 0; i < count; i++) begin	// samples within +-2^20
			sampleState = xorshift(sampleState);
			word = {{11{sampleState[20]}}, sampleState[20:0]};
			memory[(base >> 2) + 32'(i)] = word;
			y = biquadStep(longint'($signed(word)), x1, x2, y1, y2);
			expected.push_back(int'(y));
			x2 = x1;
			x1 = longint'($signed(word));
			y2 = y1;
			y1 = y;
		end
		jobBase = base;
		jobCount = count;
		issueInstr(base, 32'(count), reply);
		checkEq("result", reply, notchPkg::replyAccepted);
		prevReply = '0;
		while (!irq) begin				// progress polls until irq
			repeat (16) @(posedge clk);
			issueInstr('0, '0, reply);
			if (!irq || reply != 32'd2) begin	// request taken before the finish sees progress
				if (reply > 32'(count) || reply < prevReply) begin
					failCount++;
					$display("progress reply %0d after %0d is out of order", reply, prevReply);
				end else begin
					prevReply = reply;
				end
			end
		end
		issueInstr('0, '0, reply);
		checkEq("result", reply, 32'd2);	// finished stage
		for (i = 0; i < count; i++) begin
			checkEq($sformatf("memory[%h]", base + 32'(4 * i)), memory[(base >> 2) + 32'(i)],
				32'(expected[i]));
		end
		readStatus(notchPkg::statReceived, word);
		checkEq("statReceived", word, 32'(count));
		checkEq("irq", 32'(irq), 32'd0);	// cleared by first read
		readStatus(notchPkg::statComputed, word);
		checkEq("statComputed", word, 32'(count));
		readStatus(notchPkg::statWritten, word);
		checkEq("statWritten", word, 32'(count));
		readStatus(notchPkg::statRead, word);
		checkEq("statRead", word, 32'(4 * count));
		readStatus(notchPkg::statStage, word);
		checkEq("statStage", word, 32'(notchPkg::stageIdle));
	endtask

	// memory model samples mid cycle and drives after the edge
	initial begin
		memWaitRequest = 1'b0;
		memReadData = '0;
		memReadDataValid = 1'b0;
		waitState = rngSeed;
		forever begin
			@(negedge clk);
			if (mem.read && !memWaitRequest) begin
				readQ.push_back(memory[mem.address[10:2]]);
				dueQ.push_back(cycles + 3);
			end
			if (mem.write && !memWaitRequest) begin
				storeWrite(mem.address, mem.writeData);
			end
			@(posedge clk);
			#1;
			waitState = xorshift(waitState);
			memWaitRequest = (waitState[1:0] == 2'b00);	// stall one cycle in four
			memReadDataValid = 1'b0;
			if (dueQ.size() > 0 && dueQ[0] <= cycles) begin
				memReadDataValid = 1'b1;
				memReadData = readQ.pop_front();
				void'(dueQ.pop_front());
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		failCount++;
		$display("timeout after %0d cycles, the jobs did not complete", cycles);
		finishRun();
	end

	initial begin
		logic [31:0] reply;
		int i;
		rstN = 1'b0;
		start = 1'b0;
		dataa = '0;
		datab = '0;
		slaveRead = 1'b0;
		slaveAddress = '0;
		mismatchCount = 0;
		failCount = 0;
		jobBase = '0;
		jobCount = 0;
		sampleState = rngSeed;
		for (i = 0; i < 512; i++) begin
			memory[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;	// address dependent fill
		end
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		checkEq("done", 32'(done), 32'd0);
		checkEq("irq", 32'(irq), 32'd0);
		checkEq("mem.read", 32'(mem.read), 32'd0);
		checkEq("mem.write", 32'(mem.write), 32'd0);
		issueInstr('0, '0, reply);		// idle query
		checkEq("result", reply, notchPkg::replyIdle);
		runJob(32'h100, job1Count);
		runJob(32'h400, job2Count);		// fresh history
		finishRun();
	end

endmodule

`default_nettype wire

//--- sim.f
design/notchPkg.sv
design/sampleFifo.sv
design/sampleReader.sv
design/biquadCore.sv
design/resultWriter.sv
design/notchControl.sv
design/notchTop.sv
verif/notchTop_sva.sv
verif/notchTb.sv

//--- Makefile
# Verilator build and run of the notch accelerator testbench

VERILATOR ?= verilator
TOP ?= notchTb
DUT_TOP ?= notchTop
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
